// ==== cube_motor_drive.f ====
verilog/cube_motor_pkg.sv
verilog/step_tick_gen.sv
verilog/move_queue_ram.sv
verilog/move_sequencer.sv
verilog/motor_drive_decode.sv
verilog/cube_motor_top.sv
dv/cube_motor_checker.sv
dv/cube_motor_tb.sv

// ==== dv/cube_motor_checker.sv ====
`timescale 1ns/1ps

module cube_motor_checker import cube_motor_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_start,
    input  logic         i_exp_push,
    input  move_t        i_exp_move,
    input  motor_drive_t i_drive,
    input  move_t        i_move,
    input  logic         i_busy,
    input  logic         i_done,
    output int           o_errors,
    output int           o_moves,
    output int           o_runs
);

    move_t exp_q[$];         // moves still to be executed in this run
    move_t cur_exp   = '0;
    logic  cur_valid = 1'b0;
    logic  in_move   = 1'b0;
    logic  run_on    = 1'b0;
    logic  started   = 1'b0;
    int    step_cnt  = 0;

    initial begin
        o_errors = 0;
        o_moves  = 0;
        o_runs   = 0;
    end

    task automatic report_error(input string msg);
        o_errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // enable vector with only this face's driver low
    function automatic logic [NUM_FACES-1:0] enables_for(input face_e f);
        logic [NUM_FACES-1:0] m;
        int                   idx;
        m   = '1;
        idx = int'(f) - 1;
        if (idx >= 0 && idx < NUM_FACES) begin
            m[idx] = 1'b0;
        end
        return m;
    endfunction

    always @(posedge i_clk) begin
        if (i_rst_n) begin
            if (!started) begin   // nothing may move before the first start
                if (i_drive.en_n != '1 || i_drive.step || i_busy || i_done) begin
                    report_error("outputs not at reset values before first start");
                end
            end
            if (i_exp_push) begin
                exp_q.push_back(i_exp_move);
            end
            if (run_on && !i_busy && !i_done) begin
                report_error("busy low during a run");
            end
            if (i_start && !i_busy && !run_on) begin
                run_on  = 1'b1;
                started = 1'b1;
            end
            if (i_busy && !run_on) begin
                report_error("busy high with no run in progress");
            end

            if (i_drive.en_n != '1) begin
                if (!in_move) begin   // new move begins
                    in_move  = 1'b1;
                    step_cnt = 0;
                    o_moves++;
                    if (exp_q.size() == 0) begin
                        cur_valid = 1'b0;
                        report_error("motor enabled with no move expected");
                    end else begin
                        cur_exp   = exp_q.pop_front();
                        cur_valid = 1'b1;
                    end
                end
                if (cur_valid) begin
                    if (i_drive.en_n != enables_for(cur_exp.face)) begin
                        report_error($sformatf("enables %b, expected %b for face %0d",
                            i_drive.en_n, enables_for(cur_exp.face), cur_exp.face));
                    end
                    if (i_drive.dir != !cur_exp.ccw) begin
                        report_error($sformatf("dir %b with ccw %b", i_drive.dir, cur_exp.ccw));
                    end
                    if (i_move != cur_exp) begin
                        report_error($sformatf("current move %h, expected %h", i_move, cur_exp));
                    end
                end
                if (i_drive.step) begin
                    step_cnt++;
                end
            end else begin
                if (in_move && step_cnt != STEPS_PER_MOVE) begin
                    report_error($sformatf("move gave %0d steps, expected %0d",
                        step_cnt, STEPS_PER_MOVE));
                end
                in_move = 1'b0;
                if (i_drive.step) begin
                    report_error("step pulse with all drivers disabled");
                end
            end

            if (i_done) begin
                if (!run_on) begin
                    report_error("done pulse without an accepted start");
                end
                if (exp_q.size() != 0) begin
                    report_error($sformatf("run ended with %0d moves left", exp_q.size()));
                end
                exp_q.delete();
                run_on = 1'b0;
                o_runs++;
            end
        end
    end

endmodule

// ==== dv/cube_motor_tb.sv ====
`timescale 1ns/1ps

module cube_motor_tb import cube_motor_pkg::*; ();

    localparam int NUM_RUNS  = 6;
    localparam int MAX_MOVES = 8;
    // six runs of full length, doubled
    localparam int TIMEOUT_CYCLES =
        NUM_RUNS * MAX_MOVES * (STEPS_PER_MOVE + SETTLE_TICKS + 2) * TICK_DIV * 2;

    logic         clk;
    logic         rst_n;
    queue_wr_t    queue_wr;
    logic         start;
    motor_drive_t drive;
    move_t        cur_move;
    logic         busy;
    logic         done;
    logic         exp_push;
    move_t        exp_move;
    int           err_cnt;
    int           move_cnt;
    int           run_cnt;
    int           cycle_cnt = 0;

    always #20 clk = ~clk;

    cube_motor_top dut0 (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_queue_wr (queue_wr),
        .i_start    (start),
        .o_drive    (drive),
        .o_move     (cur_move),
        .o_busy     (busy),
        .o_done     (done)
    );

    cube_motor_checker chk0 (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_start    (start),
        .i_exp_push (exp_push),
        .i_exp_move (exp_move),
        .i_drive    (drive),
        .i_move     (cur_move),
        .i_busy     (busy),
        .i_done     (done),
        .o_errors   (err_cnt),
        .o_moves    (move_cnt),
        .o_runs     (run_cnt)
    );

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run still not finished after %0d cycles", cycle_cnt);
            $display("sim failed");
            $finish;
        end
    end

    // one queue write, optionally also handed to the checker's model list
    task automatic load_entry(input int addr, input move_t mv, input logic push);
        @(posedge clk);
        queue_wr.wr   <= 1'b1;
        queue_wr.addr <= addr[QUEUE_AW-1:0];
        queue_wr.move <= mv;
        exp_push      <= push;
        exp_move      <= mv;
        @(posedge clk);
        queue_wr <= '0;
        exp_push <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done();
        while (!done) begin
            @(posedge clk);
        end
    endtask

    initial begin
        int          n_moves;
        int unsigned rnd;
        move_t       mv;
        clk      = 1'b0;
        rst_n    = 1'b0;
        queue_wr = '0;
        start    = 1'b0;
        exp_push = 1'b0;
        exp_move = '0;
        rnd      = $urandom(35);
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (5) @(posedge clk);

        for (int r = 0; r < NUM_RUNS; r++) begin
            n_moves = (r == 0) ? 0 : int'($urandom % (MAX_MOVES + 1));   // run 0 is empty
            for (int i = 0; i < n_moves; i++) begin
                rnd     = $urandom;
                mv.ccw  = rnd[3];
                mv.face = face_e'(3'(1 + (rnd[31:8] % 6)));
                load_entry(i, mv, 1'b1);
            end
            load_entry(n_moves, '0, 1'b0);   // end marker
            pulse_start();
            if (n_moves > 0) begin
                repeat (1 + ($urandom % 200)) @(posedge clk);
                pulse_start();   // lands while busy, must be ignored
            end
            wait_done();
            repeat (3) @(posedge clk);
        end

        repeat (5) @(posedge clk);
        $display("checker summary: %0d errors, %0d moves, %0d runs", err_cnt, move_cnt, run_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== verilog/cube_motor_pkg.sv ====
package cube_motor_pkg;

    localparam int QUEUE_DEPTH    = 256;
    localparam int QUEUE_AW       = 8;
    localparam int TICK_DIV       = 20;   // system clocks per step tick
    localparam int STEPS_PER_MOVE = 50;
    localparam int SETTLE_TICKS   = 100;
    localparam int NUM_FACES      = 6;

    // counter widths derived from the timing constants
    localparam int TICK_CNT_W = $clog2(TICK_DIV);
    localparam int SEQ_CNT_W  = $clog2((STEPS_PER_MOVE > SETTLE_TICKS) ?
                                       STEPS_PER_MOVE : SETTLE_TICKS);

    // face field of a move code, 7 is never written
    typedef enum logic [2:0] {
        FACE_EMPTY = 3'd0,
        FACE_TOP   = 3'd1,
        FACE_FRONT = 3'd2,
        FACE_RIGHT = 3'd3,
        FACE_BACK  = 3'd4,
        FACE_LEFT  = 3'd5,
        FACE_DOWN  = 3'd6
    } face_e;

    typedef struct packed {
        logic  ccw;    // bit 3 of the move code
        face_e face;
    } move_t;

    typedef enum logic [1:0] {
        PH_IDLE   = 2'd0,
        PH_TURN   = 2'd1,
        PH_SETTLE = 2'd2
    } seq_phase_e;

    typedef struct packed {
        logic                wr;
        logic [QUEUE_AW-1:0] addr;
        move_t               move;
    } queue_wr_t;

    typedef struct packed {
        logic [NUM_FACES-1:0] en_n;   // active low, index 0 is top
        logic                 dir;
        logic                 step;
    } motor_drive_t;

endpackage

// ==== verilog/cube_motor_top.sv ====
`timescale 1ns/1ps

module cube_motor_top import cube_motor_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  queue_wr_t    i_queue_wr,
    input  logic         i_start,
    output motor_drive_t o_drive,
    output move_t        o_move,
    output logic         o_busy,
    output logic         o_done
);

    logic                tick;
    logic [QUEUE_AW-1:0] rd_addr;
    move_t               cur_move;
    move_t               next_move;
    seq_phase_e          phase;
    logic                step_stb;

    step_tick_gen tick0 (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .o_tick  (tick)
    );

    move_queue_ram queue0 (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wr        (i_queue_wr),
        .i_rd_addr   (rd_addr),
        .o_cur_move  (cur_move),
        .o_next_move (next_move)
    );

    move_sequencer seq0 (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_tick      (tick),
        .i_start     (i_start),
        .i_cur_move  (cur_move),
        .i_next_move (next_move),
        .o_rd_addr   (rd_addr),
        .o_phase     (phase),
        .o_move      (o_move),
        .o_step_stb  (step_stb),
        .o_busy      (o_busy),
        .o_done      (o_done)
    );

    motor_drive_decode decode0 (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_phase    (phase),
        .i_move     (o_move),
        .i_step_stb (step_stb),
        .o_drive    (o_drive)
    );

endmodule

// ==== verilog/motor_drive_decode.sv ====
`timescale 1ns/1ps

module motor_drive_decode import cube_motor_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  seq_phase_e   i_phase,
    input  move_t        i_move,
    input  logic         i_step_stb,
    output motor_drive_t o_drive
);

    motor_drive_t drive_r, drive_w;

    assign o_drive = drive_r;

    always_comb begin
        drive_w.en_n = '1;   // all drivers off by default
        drive_w.dir  = ~i_move.ccw;
        drive_w.step = i_step_stb;

        // face 1..6 maps onto enable 0..5
        for (int f = 0; f < NUM_FACES; f++) begin
            if ((i_phase == PH_TURN) && (3'(i_move.face) == 3'(f + 1))) begin
                drive_w.en_n[f] = 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            drive_r.en_n <= '1;
            drive_r.dir  <= 1'b1;
            drive_r.step <= 1'b0;
        end else begin
            drive_r <= drive_w;
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $countones(~o_drive.en_n) <= 1)
        else $error("more than one motor driver enabled");

endmodule

// ==== verilog/move_queue_ram.sv ====
`timescale 1ns/1ps

module move_queue_ram import cube_motor_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  queue_wr_t           i_wr,
    input  logic [QUEUE_AW-1:0] i_rd_addr,
    output move_t               o_cur_move,
    output move_t               o_next_move
);

    move_t               mem_r [QUEUE_DEPTH];
    logic [QUEUE_AW-1:0] next_addr;

    // wraps at the top of the queue, sequencer catches that itself
    assign next_addr = i_rd_addr + 1'b1;

    assign o_cur_move  = mem_r[i_rd_addr];
    assign o_next_move = mem_r[next_addr];   // lookahead for end-of-queue

    // all entries read back as empty after reset
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                mem_r[i] <= '0;
            end
        end else if (i_wr.wr) begin
            mem_r[i_wr.addr] <= i_wr.move;
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wr.wr |-> (3'(i_wr.move.face) != 3'd7))
        else $error("illegal face code 7 written to move queue");

endmodule

// ==== verilog/move_sequencer.sv ====
`timescale 1ns/1ps

module move_sequencer import cube_motor_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_tick,
    input  logic                i_start,
    input  move_t               i_cur_move,
    input  move_t               i_next_move,
    output logic [QUEUE_AW-1:0] o_rd_addr,
    output seq_phase_e          o_phase,
    output move_t               o_move,
    output logic                o_step_stb,
    output logic                o_busy,
    output logic                o_done
);

    seq_phase_e           phase_r, phase_w;
    logic [QUEUE_AW-1:0]  addr_r, addr_w;
    logic [SEQ_CNT_W-1:0] cnt_r, cnt_w;    // steps in turn, ticks in settle
    move_t                move_r, move_w;
    logic                 done_r, done_w;
    logic                 last_entry;
    logic                 steps_done;
    logic                 settle_done;

    assign o_rd_addr  = addr_r;
    assign o_phase    = phase_r;
    assign o_move     = move_r;
    assign o_step_stb = (phase_r == PH_TURN) && i_tick;
    assign o_busy     = (phase_r != PH_IDLE);
    assign o_done     = done_r;

    // stop on an empty follower or when the address would wrap
    assign last_entry = (i_next_move.face == FACE_EMPTY) ||
                        (addr_r == QUEUE_AW'(QUEUE_DEPTH - 1));

    assign steps_done  = i_tick && (cnt_r == SEQ_CNT_W'(STEPS_PER_MOVE - 1));
    assign settle_done = i_tick && (cnt_r == SEQ_CNT_W'(SETTLE_TICKS - 1));

    always_comb begin
        phase_w = phase_r;
        addr_w  = addr_r;
        cnt_w   = cnt_r;
        move_w  = move_r;
        done_w  = 1'b0;

        case (phase_r)
            PH_IDLE: begin
                // addr_r sits at 0 here, so i_cur_move is entry 0
                if (i_start) begin
                    if (i_cur_move.face == FACE_EMPTY) begin
                        done_w = 1'b1;   // nothing queued
                    end else begin
                        phase_w = PH_TURN;
                        move_w  = i_cur_move;
                        cnt_w   = '0;
                    end
                end
            end
            PH_TURN: begin
                if (steps_done) begin
                    phase_w = PH_SETTLE;
                    cnt_w   = '0;
                end else if (i_tick) begin
                    cnt_w = cnt_r + 1'b1;   // one strobe per tick
                end
            end
            PH_SETTLE: begin
                if (settle_done) begin
                    cnt_w = '0;
                    if (last_entry) begin
                        phase_w = PH_IDLE;
                        addr_w  = '0;
                        move_w  = '0;
                        done_w  = 1'b1;
                    end else begin
                        phase_w = PH_TURN;
                        addr_w  = addr_r + 1'b1;
                        move_w  = i_next_move;
                    end
                end else if (i_tick) begin
                    cnt_w = cnt_r + 1'b1;
                end
            end
            default: begin
                phase_w = PH_IDLE;
                addr_w  = '0;
                cnt_w   = '0;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase_r <= PH_IDLE;
            addr_r  <= '0;
            cnt_r   <= '0;
            move_r  <= '0;
            done_r  <= 1'b0;
        end else begin
            phase_r <= phase_w;
            addr_r  <= addr_w;
            cnt_r   <= cnt_w;
            move_r  <= move_w;
            done_r  <= done_w;
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_done |=> !o_done)
        else $error("done pulse longer than one cycle");

    // queue contents must never put an empty move into turn
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (phase_r == PH_TURN) |-> (move_r.face != FACE_EMPTY))
        else $error("turn phase entered with an empty move");

endmodule

// ==== verilog/step_tick_gen.sv ====
`timescale 1ns/1ps

module step_tick_gen import cube_motor_pkg::*; (
    input  logic i_clk,
    input  logic i_rst_n,
    output logic o_tick
);

    logic [TICK_CNT_W-1:0] cnt_r, cnt_w;
    logic                  wrap;

    assign wrap   = (cnt_r == TICK_CNT_W'(TICK_DIV - 1));
    assign o_tick = wrap;   // one cycle per divider period

    always_comb begin
        if (wrap) begin
            cnt_w = '0;
        end else begin
            cnt_w = cnt_r + 1'b1;
        end
    end

    // free running from reset, never held
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_r <= '0;
        end else begin
            cnt_r <= cnt_w;
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_tick |=> !o_tick)
        else $error("step tick high on two consecutive cycles");

endmodule
